/* verilog/core_config.svh */
// core build constants
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// instruction memory depth in 32-bit words
`define IMEM_DEPTH 64

// data memory depth in doublewords
`define DMEM_DEPTH 32

// first fetch address after reset
`define RESET_PC 64'h0000_0000_0000_0000

// custom opcode that ends the run
`define TRAP_OPCODE 7'h6b

`endif

/* verilog/core_types_pkg.sv */
// core datapath types
package core_types_pkg;

`include "core_config.svh"

  // data and address word
  typedef logic [63:0] xlen_t;

  typedef logic [31:0] inst_t;

  typedef logic [4:0] reg_addr_t;

  // word index into instruction memory
  typedef logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr_t;

  // one phase per cycle and halt holds until reset
  typedef enum logic [2:0] {
    PHASE_FETCH     = 3'd0,
    PHASE_DECODE    = 3'd1,
    PHASE_EXECUTE   = 3'd2,
    PHASE_MEMORY    = 3'd3,
    PHASE_WRITEBACK = 3'd4,
    PHASE_HALT      = 3'd5
  } phase_t;

endpackage

/* verilog/isa_pkg.sv */
// rv64i subset encodings
package isa_pkg;

`include "core_config.svh"

  // major opcodes in inst[6:0]
  typedef enum logic [6:0] {
    OP_LOAD   = 7'h03,
    OP_IMM    = 7'h13,
    OP_STORE  = 7'h23,
    OP_REG    = 7'h33,
    OP_LUI    = 7'h37,
    OP_BRANCH = 7'h63,
    OP_TRAP   = `TRAP_OPCODE,
    OP_JAL    = 7'h6f
  } opcode_t;

  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_SUB    = 2'd1,
    ALU_PASS_B = 2'd2
  } alu_op_t;

  // funct3 codes
  localparam logic [2:0] F3_ADD    = 3'b000;
  localparam logic [2:0] F3_DOUBLE = 3'b011;
  localparam logic [2:0] F3_BEQ    = 3'b000;
  localparam logic [2:0] F3_BNE    = 3'b001;

  // funct7 for the register-register add group
  localparam logic [6:0] F7_ADD = 7'h00;
  localparam logic [6:0] F7_SUB = 7'h20;

endpackage

/* verilog/phase_sequencer.sv */
// five phase sequencer
`timescale 1ns/100ps

module phase_sequencer
  import core_types_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   halt_i,
  output phase_t phase_o
);

  phase_t phase_q;
  phase_t phase_d;

  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      PHASE_FETCH:     phase_d = PHASE_DECODE;
      PHASE_DECODE:    phase_d = PHASE_EXECUTE;
      PHASE_EXECUTE:   phase_d = PHASE_MEMORY;
      PHASE_MEMORY:    phase_d = PHASE_WRITEBACK;
      // trap retires here and the core stops
      PHASE_WRITEBACK: phase_d = halt_i ? PHASE_HALT : PHASE_FETCH;
      PHASE_HALT:      phase_d = PHASE_HALT;
      default:         phase_d = PHASE_FETCH;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      phase_q <= PHASE_FETCH;
    end else begin
      phase_q <= phase_d;
    end
  end

  assign phase_o = phase_q;

endmodule

/* verilog/fetch_unit.sv */
// instruction fetch
`timescale 1ns/100ps

`include "core_config.svh"

module fetch_unit
  import core_types_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  phase_t     phase_i,
  input  logic       pc_jump_i,
  input  xlen_t      pc_target_i,
  input  logic       prog_we_i,
  input  imem_addr_t prog_addr_i,
  input  inst_t      prog_data_i,
  output xlen_t      pc_o,
  output inst_t      inst_o
);

  localparam int IMEM_AW = $bits(imem_addr_t);

  inst_t      imem [`IMEM_DEPTH];
  xlen_t      pc_q;
  inst_t      ir_q;
  imem_addr_t pc_idx;

  // upper pc bits wrap around the memory
  assign pc_idx = pc_q[2 +: IMEM_AW];

  // program load port
  always_ff @(posedge clock) begin
    if (prog_we_i) begin
      imem[prog_addr_i] <= prog_data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (phase_i == PHASE_FETCH) begin
      ir_q <= imem[pc_idx];
    end
  end

  // branch decision was registered at the end of execute
  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= `RESET_PC;
    end else if (phase_i == PHASE_WRITEBACK) begin
      pc_q <= pc_jump_i ? pc_target_i : pc_q + xlen_t'(4);
    end
  end

  assign pc_o   = pc_q;
  assign inst_o = ir_q;

endmodule

/* verilog/decode_unit.sv */
// instruction decode
`timescale 1ns/100ps

module decode_unit
  import core_types_pkg::*;
  import isa_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  phase_t    phase_i,
  input  inst_t     inst_i,
  input  xlen_t     pc_i,
  input  xlen_t     rs1_data_i,
  input  xlen_t     rs2_data_i,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output reg_addr_t rd_o,
  output logic      rd_wen_o,
  output logic      mem_ren_o,
  output logic      mem_wen_o,
  output logic      is_branch_o,
  output logic      branch_ne_o,
  output logic      is_jal_o,
  output logic      is_trap_o,
  output alu_op_t   alu_op_o,
  output xlen_t     op1_o,
  output xlen_t     op2_o,
  output xlen_t     store_data_o,
  output xlen_t     imm_o,
  output xlen_t     pc_o
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i_type;
  xlen_t      imm_s_type;
  xlen_t      imm_b_type;
  xlen_t      imm_u_type;
  xlen_t      imm_j_type;

  logic    d_rd_wen;
  logic    d_mem_ren;
  logic    d_mem_wen;
  logic    d_is_branch;
  logic    d_branch_ne;
  logic    d_is_jal;
  logic    d_is_trap;
  alu_op_t d_alu_op;
  xlen_t   d_op1;
  xlen_t   d_op2;
  xlen_t   d_imm;

  assign opcode = opcode_t'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  // register file is read combinationally during decode
  assign rs1_o = inst_i[19:15];
  assign rs2_o = inst_i[24:20];

  assign imm_i_type = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_type = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b_type = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u_type = {{32{inst_i[31]}}, inst_i[31:12], 12'h000};
  assign imm_j_type = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    d_rd_wen    = 1'b0;
    d_mem_ren   = 1'b0;
    d_mem_wen   = 1'b0;
    d_is_branch = 1'b0;
    d_branch_ne = 1'b0;
    d_is_jal    = 1'b0;
    d_is_trap   = 1'b0;
    d_alu_op    = ALU_ADD;
    d_op1       = rs1_data_i;
    d_op2       = imm_i_type;
    d_imm       = imm_i_type;
    case (opcode)
      OP_IMM: begin
        d_rd_wen = (funct3 == F3_ADD);
      end
      OP_REG: begin
        if (funct3 == F3_ADD && (funct7 == F7_ADD || funct7 == F7_SUB)) begin
          d_rd_wen = 1'b1;
          d_op2    = rs2_data_i;
          d_alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
        end
      end
      OP_LUI: begin
        d_rd_wen = 1'b1;
        d_op1    = '0;
        d_op2    = imm_u_type;
        d_imm    = imm_u_type;
        d_alu_op = ALU_PASS_B;
      end
      OP_LOAD: begin
        d_rd_wen  = (funct3 == F3_DOUBLE);
        d_mem_ren = (funct3 == F3_DOUBLE);
      end
      OP_STORE: begin
        d_mem_wen = (funct3 == F3_DOUBLE);
        d_op2     = imm_s_type;
        d_imm     = imm_s_type;
      end
      OP_BRANCH: begin
        // execute compares op1 against op2
        d_is_branch = (funct3 == F3_BEQ || funct3 == F3_BNE);
        d_branch_ne = (funct3 == F3_BNE);
        d_op2       = rs2_data_i;
        d_imm       = imm_b_type;
      end
      OP_JAL: begin
        d_is_jal = 1'b1;
        d_rd_wen = 1'b1;
        d_imm    = imm_j_type;
      end
      OP_TRAP: begin
        d_is_trap = 1'b1;
      end
      default: begin
        // anything else retires as a nop
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_wen_o    <= 1'b0;
      mem_ren_o   <= 1'b0;
      mem_wen_o   <= 1'b0;
      is_branch_o <= 1'b0;
      branch_ne_o <= 1'b0;
      is_jal_o    <= 1'b0;
      is_trap_o   <= 1'b0;
      alu_op_o    <= ALU_ADD;
    end else if (phase_i == PHASE_DECODE) begin
      rd_wen_o    <= d_rd_wen;
      mem_ren_o   <= d_mem_ren;
      mem_wen_o   <= d_mem_wen;
      is_branch_o <= d_is_branch;
      branch_ne_o <= d_branch_ne;
      is_jal_o    <= d_is_jal;
      is_trap_o   <= d_is_trap;
      alu_op_o    <= d_alu_op;
    end
  end

  always_ff @(posedge clock) begin
    if (phase_i == PHASE_DECODE) begin
      rd_o         <= inst_i[11:7];
      op1_o        <= d_op1;
      op2_o        <= d_op2;
      store_data_o <= rs2_data_i;
      imm_o        <= d_imm;
      pc_o         <= pc_i;
    end
  end

endmodule

/* verilog/execute_unit.sv */
// alu and branch resolution
`timescale 1ns/100ps

module execute_unit
  import core_types_pkg::*;
  import isa_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  phase_t  phase_i,
  input  alu_op_t alu_op_i,
  input  xlen_t   op1_i,
  input  xlen_t   op2_i,
  input  xlen_t   imm_i,
  input  xlen_t   pc_i,
  input  logic    is_branch_i,
  input  logic    branch_ne_i,
  input  logic    is_jal_i,
  output xlen_t   result_o,
  output logic    pc_jump_o,
  output xlen_t   pc_target_o
);

  xlen_t alu_out;
  logic  operands_eq;
  logic  take_jump;

  always_comb begin
    case (alu_op_i)
      ALU_SUB:    alu_out = op1_i - op2_i;
      ALU_PASS_B: alu_out = op2_i;
      default:    alu_out = op1_i + op2_i;
    endcase
  end

  assign operands_eq = (op1_i == op2_i);

  // beq takes on equal, bne on not equal
  assign take_jump = is_jal_i | (is_branch_i & (operands_eq ^ branch_ne_i));

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_jump_o <= 1'b0;
    end else if (phase_i == PHASE_EXECUTE) begin
      pc_jump_o <= take_jump;
    end
  end

  always_ff @(posedge clock) begin
    if (phase_i == PHASE_EXECUTE) begin
      result_o    <= alu_out;
      pc_target_o <= pc_i + imm_i;
    end
  end

endmodule

/* verilog/data_memory.sv */
// doubleword data memory
`timescale 1ns/100ps

`include "core_config.svh"

module data_memory
  import core_types_pkg::*;
(
  input  logic   clock,
  input  phase_t phase_i,
  input  logic   ren_i,
  input  logic   wen_i,
  input  xlen_t  addr_i,
  input  xlen_t  wdata_i,
  output xlen_t  rdata_o
);

  localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

  xlen_t              dmem [`DMEM_DEPTH];
  logic [DMEM_AW-1:0] word_idx;
  logic               mem_phase;

  // low three bits select a byte inside the doubleword
  assign word_idx  = addr_i[3 +: DMEM_AW];
  assign mem_phase = (phase_i == PHASE_MEMORY);

  always_ff @(posedge clock) begin
    if (mem_phase && wen_i) begin
      dmem[word_idx] <= wdata_i;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_phase && ren_i) begin
      rdata_o <= dmem[word_idx];
    end
  end

endmodule

/* verilog/register_file.sv */
// integer register file
`timescale 1ns/100ps

module register_file
  import core_types_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  reg_addr_t rd_i,
  input  logic      wen_i,
  input  xlen_t     wdata_i,
  output xlen_t     rs1_data_o,
  output xlen_t     rs2_data_o,
  output xlen_t     a0_o
);

  xlen_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // x0 always reads zero
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  assign a0_o = regs[10];

endmodule

/* verilog/sim_top.sv */
// multicycle rv64i core top
`timescale 1ns/100ps

module sim_top
  import core_types_pkg::*;
  import isa_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       prog_we_i,
  input  imem_addr_t prog_addr_i,
  input  inst_t      prog_data_i,
  output logic       commit_valid_o,
  output xlen_t      commit_pc_o,
  output inst_t      commit_inst_o,
  output logic       commit_wen_o,
  output reg_addr_t  commit_wdest_o,
  output xlen_t      commit_wdata_o,
  output logic       trap_o,
  output logic [7:0] trap_code_o
);

  phase_t    phase;
  xlen_t     pc;
  inst_t     inst;
  logic      pc_jump;
  xlen_t     pc_target;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  xlen_t     a0;
  logic      rd_wen;
  logic      mem_ren;
  logic      mem_wen;
  logic      is_branch;
  logic      branch_ne;
  logic      is_jal;
  logic      is_trap;
  alu_op_t   alu_op;
  xlen_t     op1;
  xlen_t     op2;
  xlen_t     store_data;
  xlen_t     imm;
  xlen_t     dec_pc;
  xlen_t     alu_result;
  xlen_t     load_data;
  xlen_t     wb_data;
  logic      wb_phase;
  logic      rf_wen;

  phase_sequencer phase_sequencer_i (
    .clock   (clock),
    .reset   (reset),
    .halt_i  (is_trap),
    .phase_o (phase)
  );

  fetch_unit fetch_unit_i (
    .clock       (clock),
    .reset       (reset),
    .phase_i     (phase),
    .pc_jump_i   (pc_jump),
    .pc_target_i (pc_target),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .pc_o        (pc),
    .inst_o      (inst)
  );

  decode_unit decode_unit_i (
    .clock        (clock),
    .reset        (reset),
    .phase_i      (phase),
    .inst_i       (inst),
    .pc_i         (pc),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rd_o         (rd),
    .rd_wen_o     (rd_wen),
    .mem_ren_o    (mem_ren),
    .mem_wen_o    (mem_wen),
    .is_branch_o  (is_branch),
    .branch_ne_o  (branch_ne),
    .is_jal_o     (is_jal),
    .is_trap_o    (is_trap),
    .alu_op_o     (alu_op),
    .op1_o        (op1),
    .op2_o        (op2),
    .store_data_o (store_data),
    .imm_o        (imm),
    .pc_o         (dec_pc)
  );

  execute_unit execute_unit_i (
    .clock       (clock),
    .reset       (reset),
    .phase_i     (phase),
    .alu_op_i    (alu_op),
    .op1_i       (op1),
    .op2_i       (op2),
    .imm_i       (imm),
    .pc_i        (dec_pc),
    .is_branch_i (is_branch),
    .branch_ne_i (branch_ne),
    .is_jal_i    (is_jal),
    .result_o    (alu_result),
    .pc_jump_o   (pc_jump),
    .pc_target_o (pc_target)
  );

  data_memory data_memory_i (
    .clock   (clock),
    .phase_i (phase),
    .ren_i   (mem_ren),
    .wen_i   (mem_wen),
    .addr_i  (alu_result),
    .wdata_i (store_data),
    .rdata_o (load_data)
  );

  register_file register_file_i (
    .clock      (clock),
    .reset      (reset),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rd_i       (rd),
    .wen_i      (rf_wen),
    .wdata_i    (wb_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .a0_o       (a0)
  );

  assign wb_phase = (phase == PHASE_WRITEBACK);
  assign rf_wen   = wb_phase & rd_wen;

  // jal writes back its return address
  always_comb begin
    if (mem_ren) begin
      wb_data = load_data;
    end else if (is_jal) begin
      wb_data = dec_pc + xlen_t'(4);
    end else begin
      wb_data = alu_result;
    end
  end

  // commit pulse lands the cycle after writeback
  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid_o <= 1'b0;
      trap_o         <= 1'b0;
    end else begin
      commit_valid_o <= wb_phase;
      if (wb_phase && is_trap) begin
        trap_o <= 1'b1;
      end
    end
  end

  // commit payload holds until the next writeback
  always_ff @(posedge clock) begin
    if (wb_phase) begin
      commit_pc_o    <= pc;
      commit_inst_o  <= inst;
      commit_wen_o   <= rd_wen && (rd != '0);
      commit_wdest_o <= rd;
      commit_wdata_o <= wb_data;
      trap_code_o    <= a0[7:0];
    end
  end

endmodule

/* verification/sim_top_assert.sv */
// commit and trap checks
`timescale 1ns/100ps

`include "core_config.svh"

module sim_top_assert
  import core_types_pkg::*;
(
  input logic      clock,
  input logic      reset,
  input logic      commit_valid_i,
  input xlen_t     commit_pc_i,
  input logic      commit_wen_i,
  input reg_addr_t commit_wdest_i,
  input logic      trap_i
);

  int unsigned failures = 0;
  logic [3:0]  since_commit;
  logic        first_pending;

  // cycles since the last commit pulse, or since reset
  always_ff @(posedge clock) begin
    if (reset) begin
      since_commit  <= 4'd0;
      first_pending <= 1'b1;
    end else if (commit_valid_i) begin
      since_commit  <= 4'd1;
      first_pending <= 1'b0;
    end else if (since_commit != 4'hf) begin
      since_commit <= since_commit + 4'd1;
    end
  end

  reset_clears: assert property (@(posedge clock)
    reset |=> !commit_valid_i && !trap_i)
  else begin
    failures++;
    $error("commit or trap high right after reset");
  end

  first_commit_pc: assert property (@(posedge clock) disable iff (reset)
    first_pending && commit_valid_i |-> commit_pc_i == `RESET_PC)
  else begin
    failures++;
    $error("first commit is not at the reset pc");
  end

  commit_spacing: assert property (@(posedge clock) disable iff (reset)
    commit_valid_i |-> since_commit == 4'd5)
  else begin
    failures++;
    $error("commit pulse not five cycles after the previous one");
  end

  commit_not_late: assert property (@(posedge clock) disable iff (reset)
    since_commit == 4'd5 && !trap_i |-> commit_valid_i)
  else begin
    failures++;
    $error("commit pulse missing five cycles after the previous one");
  end

  commit_one_cycle: assert property (@(posedge clock) disable iff (reset)
    commit_valid_i |=> !commit_valid_i)
  else begin
    failures++;
    $error("commit pulse longer than one cycle");
  end

  no_x0_write: assert property (@(posedge clock) disable iff (reset)
    commit_valid_i |-> !(commit_wen_i && commit_wdest_i == 5'd0))
  else begin
    failures++;
    $error("commit reports a write to x0");
  end

  trap_with_commit: assert property (@(posedge clock) disable iff (reset)
    $rose(trap_i) |-> commit_valid_i)
  else begin
    failures++;
    $error("trap rose without a commit pulse");
  end

  trap_sticky: assert property (@(posedge clock) disable iff (reset)
    trap_i |=> trap_i)
  else begin
    failures++;
    $error("trap dropped before reset");
  end

  no_commit_after_trap: assert property (@(posedge clock) disable iff (reset)
    trap_i |=> !commit_valid_i)
  else begin
    failures++;
    $error("commit pulse after the trap");
  end

endmodule

bind sim_top sim_top_assert sim_top_assert_i (
  .clock          (clock),
  .reset          (reset),
  .commit_valid_i (commit_valid_o),
  .commit_pc_i    (commit_pc_o),
  .commit_wen_i   (commit_wen_o),
  .commit_wdest_i (commit_wdest_o),
  .trap_i         (trap_o)
);

/* verification/sim_top_tb.sv */
// multicycle core testbench
`timescale 1ns/100ps

`include "core_config.svh"

module sim_top_tb
  import core_types_pkg::*;
();

  localparam int          COMMIT_TIMEOUT = 20;
  localparam int          QUIET_CYCLES   = 15;
  localparam logic [31:0] LFSR_SEED      = 32'h6ab0_b60c;
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

  logic       clock;
  logic       reset;
  logic       prog_we;
  imem_addr_t prog_addr;
  inst_t      prog_data;
  logic       commit_valid;
  xlen_t      commit_pc;
  inst_t      commit_inst;
  logic       commit_wen;
  reg_addr_t  commit_wdest;
  xlen_t      commit_wdata;
  logic       trap;
  logic [7:0] trap_code;

  logic [31:0] lfsr_state;
  inst_t       prog_words [`IMEM_DEPTH];
  int          prog_len;
  xlen_t       prog_pc;
  xlen_t       model_regs [32];
  xlen_t       model_mem [`DMEM_DEPTH];
  xlen_t       exp_pc [$];
  inst_t       exp_inst [$];
  logic        exp_wen [$];
  reg_addr_t   exp_rd [$];
  xlen_t       exp_data [$];
  int          errors;
  int          assert_failures;

  sim_top sim_top_i (
    .clock          (clock),
    .reset          (reset),
    .prog_we_i      (prog_we),
    .prog_addr_i    (prog_addr),
    .prog_data_i    (prog_data),
    .commit_valid_o (commit_valid),
    .commit_pc_o    (commit_pc),
    .commit_inst_o  (commit_inst),
    .commit_wen_o   (commit_wen),
    .commit_wdest_o (commit_wdest),
    .commit_wdata_o (commit_wdata),
    .trap_o         (trap),
    .trap_code_o    (trap_code)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #4 clock = ~clock;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < count; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return val;
  endfunction

  function automatic xlen_t sext12(input logic [11:0] imm);
    return {{52{imm[11]}}, imm};
  endfunction

  function automatic inst_t i_format(input logic [6:0] opc, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t r_format(input logic [6:0] f7, input reg_addr_t rd,
                                     input reg_addr_t rs1, input reg_addr_t rs2);
    return {f7, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  function automatic inst_t s_format(input reg_addr_t rs1, input reg_addr_t rs2,
                                     input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'h23};
  endfunction

  function automatic inst_t b_format(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic inst_t u_format(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, 7'h37};
  endfunction

  function automatic inst_t j_format(input reg_addr_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // stores the word and queues the commit it should produce
  task automatic place(input inst_t word, input logic wen, input reg_addr_t rd,
                       input xlen_t data);
    prog_words[imem_addr_t'(prog_pc >> 2)] = word;
    exp_pc.push_back(prog_pc);
    exp_inst.push_back(word);
    exp_wen.push_back(wen && rd != 5'd0);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
    if (wen && rd != 5'd0) begin
      model_regs[rd] = data;
    end
    prog_pc = prog_pc + 64'd4;
  endtask

  // slot stepped over by a taken branch or jump
  task automatic skip_slot();
    prog_words[imem_addr_t'(prog_pc >> 2)] = i_format(7'h13, 3'b000, 5'd31, 5'd0, 12'h7ff);
    prog_pc = prog_pc + 64'd4;
  endtask

  task automatic addi(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
    place(i_format(7'h13, 3'b000, rd, rs1, imm), 1'b1, rd, model_regs[rs1] + sext12(imm));
  endtask

  task automatic reg_op(input logic sub, input reg_addr_t rd, input reg_addr_t rs1,
                        input reg_addr_t rs2);
    xlen_t data;
    data = sub ? model_regs[rs1] - model_regs[rs2] : model_regs[rs1] + model_regs[rs2];
    place(r_format(sub ? 7'h20 : 7'h00, rd, rs1, rs2), 1'b1, rd, data);
  endtask

  task automatic lui(input reg_addr_t rd, input logic [19:0] imm);
    place(u_format(rd, imm), 1'b1, rd, {{32{imm[19]}}, imm, 12'h000});
  endtask

  task automatic store_double(input reg_addr_t rs2, input reg_addr_t rs1,
                              input logic [11:0] imm);
    xlen_t addr;
    addr = model_regs[rs1] + sext12(imm);
    model_mem[addr[7:3]] = model_regs[rs2];
    place(s_format(rs1, rs2, imm), 1'b0, 5'd0, '0);
  endtask

  task automatic load_double(input reg_addr_t rd, input reg_addr_t rs1,
                             input logic [11:0] imm);
    xlen_t addr;
    addr = model_regs[rs1] + sext12(imm);
    place(i_format(7'h03, 3'b011, rd, rs1, imm), 1'b1, rd, model_mem[addr[7:3]]);
  endtask

  // both branches jump 8 bytes ahead when taken
  task automatic branch(input logic ne, input reg_addr_t rs1, input reg_addr_t rs2);
    logic taken;
    taken = (model_regs[rs1] == model_regs[rs2]) ^ ne;
    place(b_format(ne ? 3'b001 : 3'b000, rs1, rs2, 13'd8), 1'b0, 5'd0, '0);
    if (taken) begin
      skip_slot();
    end
  endtask

  task automatic jal(input reg_addr_t rd);
    place(j_format(rd, 21'd8), 1'b1, rd, prog_pc + 64'd4);
    skip_slot();
  endtask

  task automatic build_program();
    addi(5'd1, 5'd0, 12'(rand_bits(12)));
    addi(5'd2, 5'd1, 12'(rand_bits(12)));
    addi(5'd3, 5'd0, 12'(rand_bits(12)));
    reg_op(1'b0, 5'd4, 5'd1, 5'd2);
    reg_op(1'b1, 5'd5, 5'd4, 5'd3);
    lui(5'd8, 20'(rand_bits(20)));
    addi(5'd8, 5'd8, 12'(rand_bits(12)));
    addi(5'd6, 5'd0, 12'h080);
    store_double(5'd8, 5'd6, 12'h008);
    load_double(5'd9, 5'd6, 12'h008);
    branch(1'b0, 5'd9, 5'd8);
    branch(1'b1, 5'd9, 5'd8);
    jal(5'd11);
    addi(5'd0, 5'd1, 12'h123);
    addi(5'd10, 5'd0, 12'(rand_bits(12)));
    place({25'd0, `TRAP_OPCODE}, 1'b0, 5'd0, '0);
    prog_len = int'(prog_pc >> 2);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    assert (got == expected) else begin
      errors++;
      $display("Fail %0t %s got %h expected %h", $time, name, got, expected);
    end
  endtask

  task automatic check_commit(input int idx);
    check_value("commit_pc_o", commit_pc, exp_pc[idx]);
    check_value("commit_inst_o", 64'(commit_inst), 64'(exp_inst[idx]));
    check_value("commit_wen_o", 64'(commit_wen), 64'(exp_wen[idx]));
    if (exp_wen[idx]) begin
      check_value("commit_wdest_o", 64'(commit_wdest), 64'(exp_rd[idx]));
      check_value("commit_wdata_o", commit_wdata, exp_data[idx]);
    end
    check_value("trap_o", 64'(trap), 64'(idx == exp_pc.size() - 1));
  endtask

  task automatic wait_commit(output logic timed_out);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!commit_valid && cycles < COMMIT_TIMEOUT);
    timed_out = !commit_valid;
  endtask

  initial begin
    logic timed_out;
    reset      = 1'b1;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    errors     = 0;
    timed_out  = 1'b0;
    lfsr_state = LFSR_SEED;
    prog_pc    = `RESET_PC;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    build_program();

    // reset stays up through the load and five more cycles
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clock);
      prog_we   = 1'b1;
      prog_addr = imem_addr_t'(i);
      prog_data = prog_words[i];
    end
    @(negedge clock);
    prog_we = 1'b0;
    repeat (5) @(negedge clock);
    reset = 1'b0;

    for (int idx = 0; idx < exp_pc.size(); idx++) begin
      wait_commit(timed_out);
      if (timed_out) begin
        errors++;
        $display("Timeout: no commit pulse for instruction %0d by %0t", idx, $time);
        break;
      end
      check_commit(idx);
    end

    if (!timed_out) begin
      check_value("trap_code_o", 64'(trap_code), 64'(model_regs[10][7:0]));
      // the core must stay halted
      repeat (QUIET_CYCLES) begin
        @(negedge clock);
        check_value("commit_valid_o", 64'(commit_valid), 64'd0);
        check_value("trap_o", 64'(trap), 64'd1);
      end
    end

    assert_failures = sim_top_i.sim_top_assert_i.failures;
    $display("Error count: %0d commit check errors, %0d assertion failures",
             errors, assert_failures);
    if (errors == 0 && assert_failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+verilog
verilog/core_types_pkg.sv
verilog/isa_pkg.sv
verilog/phase_sequencer.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/data_memory.sv
verilog/register_file.sv
verilog/sim_top.sv
verification/sim_top_assert.sv
verification/sim_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= sim_top_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= All tests passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard verilog/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
